/* common/rv_pkg.sv */
// shared widths, encodings and control enums for the rv32i core, imported by every core module
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int shamt_w    = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // major opcodes, inst[6:0]
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, sra, srai

    localparam logic [xlen-1:0] inst_ebreak = 32'h0010_0073;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {src_a_rs1, src_a_pc, src_a_zero} src_a_t;

    typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} src_b_t;

    typedef enum logic [2:0] {
        br_never, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
    } br_cond_t;

    typedef enum logic [2:0] {pc_seq, pc_branch, pc_jal, pc_jalr, pc_hold} pc_sel_t;

endpackage

`default_nettype wire

/* hw/pc_unit.sv */
// program counter with next-pc select and sticky halt, one update per instruction
`default_nettype none
`timescale 1ns/100ps

module pc_unit (
    input  wire                     clk,
    input  wire                     rst,
    input  wire rv_pkg::pc_sel_t    pc_sel,
    input  wire                     taken,
    input  wire [rv_pkg::xlen-1:0]  imm,
    input  wire [rv_pkg::xlen-1:0]  jalr_target,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic                    halted
);
    import rv_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_plus_imm;  // branch and jal target
    logic [xlen-1:0] next_pc;

    assign pc_plus4    = pc + xlen'(4);
    assign pc_plus_imm = pc + imm;

    always_comb begin
        if (halted) begin
            next_pc = pc;  // stuck until reset
        end else begin
            case (pc_sel)
                pc_seq:    next_pc = pc_plus4;
                pc_branch: next_pc = taken ? pc_plus_imm : pc_plus4;
                pc_jal:    next_pc = pc_plus_imm;
                pc_jalr:   next_pc = jalr_target;
                pc_hold:   next_pc = pc;
                default:   next_pc = pc_plus4;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else begin
            pc <= next_pc;
            if (!halted && pc_sel == pc_hold) begin
                halted <= 1'b1;  // ebreak seen
            end
        end
    end

endmodule

`default_nettype wire

/* hw/decoder.sv */
// combinational rv32i decoder, turns one instruction word into control fields and an immediate
`default_nettype none
`timescale 1ns/100ps

module decoder (
    input  wire [rv_pkg::xlen-1:0]        inst,
    output logic [rv_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_pkg::reg_addr_w-1:0] rd,
    output logic [rv_pkg::xlen-1:0]       imm,
    output rv_pkg::alu_op_t               alu_op,
    output rv_pkg::src_a_t                src_a,
    output rv_pkg::src_b_t                src_b,
    output rv_pkg::br_cond_t              br_cond,
    output rv_pkg::pc_sel_t               pc_sel,
    output logic                          wen,
    output logic                          halt,
    output logic                          unknown_code
);
    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic            illegal;

    // shared by OP and OP-IMM, alt selects sub / sra
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            f3_add_sub: op = alt ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            default:    op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // sign extension from inst[31] in every format
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign unknown_code = illegal;

    always_comb begin
        imm     = imm_i;
        alu_op  = alu_add;
        src_a   = src_a_rs1;
        src_b   = src_b_rs2;
        br_cond = br_never;
        pc_sel  = pc_seq;
        wen     = 1'b0;
        halt    = 1'b0;
        illegal = 1'b0;

        case (opcode)
            op_lui: begin
                imm   = imm_u;
                src_a = src_a_zero;
                src_b = src_b_imm;
                wen   = 1'b1;
            end
            op_auipc: begin
                imm   = imm_u;
                src_a = src_a_pc;
                src_b = src_b_imm;
                wen   = 1'b1;
            end
            op_jal: begin
                imm    = imm_j;
                src_a  = src_a_pc;   // link = pc + 4
                src_b  = src_b_four;
                pc_sel = pc_jal;
                wen    = 1'b1;
            end
            op_jalr: begin
                src_a   = src_a_pc;
                src_b   = src_b_four;
                pc_sel  = pc_jalr;
                wen     = 1'b1;
                illegal = (funct3 != 3'b000);
            end
            op_branch: begin
                imm    = imm_b;
                pc_sel = pc_branch;
                case (funct3)
                    f3_beq:  br_cond = br_eq;
                    f3_bne:  br_cond = br_ne;
                    f3_blt:  br_cond = br_lt;
                    f3_bge:  br_cond = br_ge;
                    f3_bltu: br_cond = br_ltu;
                    f3_bgeu: br_cond = br_geu;
                    default: illegal = 1'b1;  // 010, 011 reserved
                endcase
            end
            op_imm: begin
                src_b  = src_b_imm;
                alu_op = arith_op(funct3, funct3 == f3_srl_sra && inst[30]);
                wen    = 1'b1;
                if (funct3 == f3_sll) begin
                    illegal = (funct7 != f7_base);
                end else if (funct3 == f3_srl_sra) begin
                    illegal = (funct7 != f7_base) && (funct7 != f7_alt);
                end
            end
            op_reg: begin
                alu_op = arith_op(funct3, funct7 == f7_alt);
                wen    = 1'b1;
                if (funct7 == f7_alt) begin
                    illegal = (funct3 != f3_add_sub) && (funct3 != f3_srl_sra);
                end else begin
                    illegal = (funct7 != f7_base);
                end
            end
            op_system: begin
                if (inst == inst_ebreak) begin
                    pc_sel = pc_hold;
                    halt   = 1'b1;
                end else begin
                    illegal = 1'b1;  // ecall and csr not supported
                end
            end
            default: illegal = 1'b1;
        endcase

        // illegal word retires nothing and falls through
        if (illegal) begin
            wen     = 1'b0;
            pc_sel  = pc_seq;
            br_cond = br_never;
        end
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
// integer register file x0..x31, two async reads and one clocked write port
`default_nettype none
`timescale 1ns/100ps

module reg_file (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           wen,
    input  wire [rv_pkg::reg_addr_w-1:0]  waddr,
    input  wire [rv_pkg::xlen-1:0]        wdata,
    input  wire [rv_pkg::reg_addr_w-1:0]  raddr1,
    input  wire [rv_pkg::reg_addr_w-1:0]  raddr2,
    output logic [rv_pkg::xlen-1:0]       rdata1,
    output logic [rv_pkg::xlen-1:0]       rdata2
);
    import rv_pkg::*;

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;  // x0 never written
        end
    end

    // x0 stays zero from reset on
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

/* hw/alu.sv */
// operand muxes, arithmetic unit, branch compare and jalr target for the single-cycle core
`default_nettype none
`timescale 1ns/100ps

module alu (
    input  wire rv_pkg::alu_op_t    alu_op,
    input  wire rv_pkg::src_a_t     src_a,
    input  wire rv_pkg::src_b_t     src_b,
    input  wire rv_pkg::br_cond_t   br_cond,
    input  wire [rv_pkg::xlen-1:0]  rdata1,
    input  wire [rv_pkg::xlen-1:0]  rdata2,
    input  wire [rv_pkg::xlen-1:0]  imm,
    input  wire [rv_pkg::xlen-1:0]  pc,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    taken,
    output logic [rv_pkg::xlen-1:0] jalr_target
);
    import rv_pkg::*;

    logic [xlen-1:0]    op_a;
    logic [xlen-1:0]    op_b;
    logic [shamt_w-1:0] shamt;
    logic [xlen:0]      br_diff;  // extra msb is the unsigned borrow
    logic               cmp_eq;
    logic               cmp_lt;
    logic               cmp_ltu;

    always_comb begin
        case (src_a)
            src_a_pc:   op_a = pc;
            src_a_zero: op_a = '0;
            default:    op_a = rdata1;
        endcase
        case (src_b)
            src_b_imm:  op_b = imm;
            src_b_four: op_b = xlen'(4);
            default:    op_b = rdata2;
        endcase
    end

    assign shamt = op_b[shamt_w-1:0];

    always_comb begin
        case (alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> shamt;
            alu_sra:    result = $unsigned($signed(op_a) >>> shamt);
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;
            default:    result = op_a + op_b;
        endcase
    end

    // one subtractor serves both signed and unsigned compare
    assign br_diff = {1'b0, rdata1} - {1'b0, rdata2};
    assign cmp_eq  = (br_diff[xlen-1:0] == '0);
    assign cmp_ltu = br_diff[xlen];
    assign cmp_lt  = (rdata1[xlen-1] != rdata2[xlen-1]) ? rdata1[xlen-1] : br_diff[xlen-1];

    always_comb begin
        case (br_cond)
            br_eq:   taken = cmp_eq;
            br_ne:   taken = !cmp_eq;
            br_lt:   taken = cmp_lt;
            br_ge:   taken = !cmp_lt;
            br_ltu:  taken = cmp_ltu;
            br_geu:  taken = !cmp_ltu;
            default: taken = 1'b0;
        endcase
    end

    assign jalr_target = (rdata1 + imm) & ~xlen'(1);  // lsb cleared per spec

endmodule

`default_nettype wire

/* hw/rv_core.sv */
// top of the single-cycle rv32i core, fetches from a combinational port and exposes the retire port
`default_nettype none
`timescale 1ns/100ps

module rv_core (
    input  wire                               clk,
    input  wire                               rst,
    input  wire [rv_pkg::xlen-1:0]            inst,
    output logic [rv_pkg::xlen-1:0]           pc,
    output logic                              unknown_code,
    output logic                              halted,
    output logic                              retire_valid,
    output logic [rv_pkg::xlen-1:0]           retire_pc,
    output logic [rv_pkg::reg_addr_w-1:0]     retire_rd,
    output logic [rv_pkg::xlen-1:0]           retire_data
);
    import rv_pkg::*;

    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
    alu_op_t               alu_op;
    src_a_t                src_a;
    src_b_t                src_b;
    br_cond_t              br_cond;
    pc_sel_t               pc_sel;
    logic                  wen;      // decoder write request
    logic                  halt;     // ebreak in decode
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [xlen-1:0]       result;
    logic                  taken;
    logic [xlen-1:0]       jalr_target;

    pc_unit pc_unit_i (
        .clk         (clk),
        .rst         (rst),
        .pc_sel      (pc_sel),
        .taken       (taken),
        .imm         (imm),
        .jalr_target (jalr_target),
        .pc          (pc),
        .halted      (halted)
    );

    decoder decoder_i (
        .inst         (inst),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .alu_op       (alu_op),
        .src_a        (src_a),
        .src_b        (src_b),
        .br_cond      (br_cond),
        .pc_sel       (pc_sel),
        .wen          (wen),
        .halt         (halt),
        .unknown_code (unknown_code)
    );

    // write port follows retire, so nothing lands during reset or halt
    reg_file reg_file_i (
        .clk    (clk),
        .rst    (rst),
        .wen    (retire_valid),
        .waddr  (rd),
        .wdata  (result),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu alu_i (
        .alu_op      (alu_op),
        .src_a       (src_a),
        .src_b       (src_b),
        .br_cond     (br_cond),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .imm         (imm),
        .pc          (pc),
        .result      (result),
        .taken       (taken),
        .jalr_target (jalr_target)
    );

    assign retire_valid = wen & ~halt & ~halted & ~rst;
    assign retire_pc    = pc;
    assign retire_rd    = rd;
    assign retire_data  = result;

endmodule

`default_nettype wire

/* tb/tb_rv_core.sv */
// testbench for rv_core, runs a table-driven rv32i program and checks the retire port every cycle
`default_nettype none
`timescale 1ns/100ps

module tb_rv_core;
    import rv_pkg::*;

    localparam int clk_period  = 100;
    localparam int reset_len   = 5;
    localparam int halt_cycles = 8;  // cycles watched after ebreak

    // one executed instruction and what the retire port must show for it
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        unk;
    } row_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [xlen-1:0]       inst;
    logic [xlen-1:0]       pc;
    logic                  unknown_code;
    logic                  halted;
    logic                  retire_valid;
    logic [xlen-1:0]       retire_pc;
    logic [reg_addr_w-1:0] retire_rd;
    logic [xlen-1:0]       retire_data;

    row_t        prog[$];
    bit          prog_ready;
    int          errors;
    int          checks;
    int          cur_row;
    logic [31:0] halt_pc;

    rv_core rv_core_i (
        .clk          (clk),
        .rst          (rst),
        .inst         (inst),
        .pc           (pc),
        .unknown_code (unknown_code),
        .halted       (halted),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #(clk_period / 2) clk = ~clk;

    // instruction encoders, field order as in the isa manual
    function automatic logic [31:0] r_word(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_reg};
    endfunction

    function automatic logic [31:0] i_word(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] op);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] u_word(input int imm20, input int rd, input logic [6:0] op);
        return {20'(imm20), 5'(rd), op};
    endfunction

    function automatic logic [31:0] b_word(input int off, input int rs2, input int rs1,
                                           input logic [2:0] f3);
        logic [12:0] b;
        b = 13'(off);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], op_branch};
    endfunction

    function automatic logic [31:0] j_word(input int off, input int rd);
        logic [20:0] j;
        j = 21'(off);
        return {j[20], j[10:1], j[11], j[19:12], 5'(rd), op_jal};
    endfunction

    // instruction memory model, backed by the program table
    function automatic logic [31:0] fetch(input logic [31:0] addr);
        logic [31:0] word;
        word = {addr[31:2] ^ {28'h0, addr[1:0]}, 2'b00};  // unmapped, low bits 00 are illegal
        foreach (prog[i]) begin
            if (prog[i].pc == addr) begin
                word = prog[i].inst;
            end
        end
        return word;
    endfunction

    task automatic write_row(input logic [31:0] word, input logic [31:0] at, input int rd,
                             input logic [31:0] data);
        prog.push_back('{inst: word, pc: at, valid: 1'b1, rd: 5'(rd), data: data, unk: 1'b0});
    endtask

    // branches, illegal words and ebreak retire nothing
    task automatic silent_row(input logic [31:0] word, input logic [31:0] at, input logic unk);
        prog.push_back('{inst: word, pc: at, valid: 1'b0, rd: 5'd0, data: 32'h0, unk: unk});
    endtask

    task automatic check_field(input string field, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: row %0d %s is %h, expected %h",
                     $time, cur_row, field, got, exp);
        end
    endtask

    task automatic build_program();
        // arithmetic and logic, registers start at zero
        write_row(i_word(5, 0, f3_add_sub, 1, op_imm),     32'h00, 1, 32'd5);
        write_row(i_word(-3, 0, f3_add_sub, 2, op_imm),    32'h04, 2, 32'hffff_fffd);
        write_row(r_word(f7_base, 2, 1, f3_add_sub, 3),    32'h08, 3, 32'd2);
        write_row(r_word(f7_alt, 2, 1, f3_add_sub, 4),     32'h0c, 4, 32'd8);
        write_row(u_word(32'h80000, 5, op_lui),            32'h10, 5, 32'h8000_0000);
        write_row(u_word(32'h00001, 6, op_auipc),          32'h14, 6, 32'h0000_1014);
        write_row(r_word(f7_alt, 1, 5, f3_srl_sra, 7),     32'h18, 7, 32'hfc00_0000);
        write_row(r_word(f7_base, 1, 5, f3_srl_sra, 8),    32'h1c, 8, 32'h0400_0000);
        write_row(r_word(f7_base, 1, 2, f3_slt, 9),        32'h20, 9, 32'd1);   // -3 < 5
        write_row(r_word(f7_base, 1, 2, f3_sltu, 10),      32'h24, 10, 32'd0);  // big > 5
        write_row(r_word(f7_base, 2, 1, f3_xor, 11),       32'h28, 11, 32'hffff_fff8);
        write_row(r_word(f7_base, 4, 1, f3_or, 12),        32'h2c, 12, 32'd13);
        write_row(r_word(f7_base, 4, 2, f3_and, 13),       32'h30, 13, 32'd8);
        write_row(r_word(f7_base, 3, 1, f3_sll, 14),       32'h34, 14, 32'd20);
        write_row(i_word(32'h401, 2, f3_srl_sra, 15, op_imm), 32'h38, 15, 32'hffff_fffe);
        write_row(i_word(0, 2, f3_slt, 16, op_imm),        32'h3c, 16, 32'd1);
        write_row(i_word(-1, 1, f3_sltu, 17, op_imm),      32'h40, 17, 32'd1);
        write_row(i_word(32'hff, 1, f3_xor, 18, op_imm),   32'h44, 18, 32'h0000_00fa);
        write_row(i_word(32'hf0, 0, f3_or, 19, op_imm),    32'h48, 19, 32'h0000_00f0);
        write_row(i_word(32'hff, 2, f3_and, 20, op_imm),   32'h4c, 20, 32'h0000_00fd);
        write_row(i_word(4, 1, f3_sll, 21, op_imm),        32'h50, 21, 32'h0000_0050);
        write_row(i_word(28, 2, f3_srl_sra, 22, op_imm),   32'h54, 22, 32'h0000_000f);
        // x0 as target and as source
        write_row(i_word(7, 1, f3_add_sub, 0, op_imm),     32'h58, 0, 32'd12);
        write_row(r_word(f7_base, 1, 0, f3_add_sub, 23),   32'h5c, 23, 32'd5);
        // reserved funct7 aimed at x1, which must keep its value
        silent_row(r_word(7'b0000001, 4, 4, f3_add_sub, 1), 32'h60, 1'b1);
        write_row(i_word(0, 1, f3_add_sub, 24, op_imm),    32'h64, 24, 32'd5);
        // each branch condition taken, then not taken
        silent_row(b_word(8, 23, 1, f3_beq),  32'h68, 1'b0);
        silent_row(b_word(8, 2, 1, f3_beq),   32'h70, 1'b0);
        silent_row(b_word(8, 2, 1, f3_bne),   32'h74, 1'b0);
        silent_row(b_word(8, 23, 1, f3_bne),  32'h7c, 1'b0);
        silent_row(b_word(8, 1, 2, f3_blt),   32'h80, 1'b0);
        silent_row(b_word(8, 2, 1, f3_blt),   32'h88, 1'b0);
        silent_row(b_word(8, 2, 1, f3_bge),   32'h8c, 1'b0);
        silent_row(b_word(8, 1, 2, f3_bge),   32'h94, 1'b0);
        silent_row(b_word(8, 2, 1, f3_bltu),  32'h98, 1'b0);
        silent_row(b_word(8, 1, 2, f3_bltu),  32'ha0, 1'b0);
        silent_row(b_word(8, 1, 2, f3_bgeu),  32'ha4, 1'b0);
        silent_row(b_word(8, 2, 1, f3_bgeu),  32'hac, 1'b0);
        // jumps, including a backward branch
        write_row(j_word(16, 25),                          32'hb0, 25, 32'h0000_00b4);
        silent_row(b_word(-8, 0, 0, f3_beq),               32'hc0, 1'b0);
        write_row(i_word(32'hd1, 0, f3_add_sub, 26, op_imm), 32'hb8, 26, 32'h0000_00d1);
        write_row(i_word(32'h30, 26, 3'b000, 27, op_jalr), 32'hbc, 27, 32'h0000_00c0);
        write_row(r_word(f7_base, 25, 27, f3_add_sub, 28), 32'h100, 28, 32'h0000_0174);
        silent_row(inst_ebreak, 32'h104, 1'b0);
    endtask

    initial begin
        wait (prog_ready);
        #((prog.size() + 20) * clk_period);
        $display("timeout: core did not reach the end of the program in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst     = 1'b1;
        inst    = i_word(1, 0, f3_add_sub, 1, op_imm);  // must not retire under reset
        errors  = 0;
        checks  = 0;
        cur_row = -1;
        build_program();
        prog_ready = 1'b1;

        repeat (reset_len - 1) begin
            @(posedge clk);
            @(negedge clk);
            check_field("pc in reset", pc, reset_pc);
            check_field("retire_valid in reset", 32'(retire_valid), 32'd0);
        end
        @(posedge clk);
        #1;
        rst = 1'b0;

        for (int k = 0; k < prog.size(); k++) begin
            cur_row = k;
            check_field("pc", pc, prog[k].pc);
            inst = fetch(pc);
            @(negedge clk);
            check_field("retire_valid", 32'(retire_valid), 32'(prog[k].valid));
            check_field("unknown_code", 32'(unknown_code), 32'(prog[k].unk));
            if (prog[k].valid) begin
                check_field("retire_pc", retire_pc, prog[k].pc);
                check_field("retire_rd", 32'(retire_rd), 32'(prog[k].rd));
                check_field("retire_data", retire_data, prog[k].data);
            end
            @(posedge clk);
            #1;
        end

        // a legal write after ebreak must stay invisible
        halt_pc = prog[prog.size() - 1].pc;
        inst    = i_word(1, 0, f3_add_sub, 1, op_imm);
        repeat (halt_cycles) begin
            @(negedge clk);
            check_field("halted", 32'(halted), 32'd1);
            check_field("pc while halted", pc, halt_pc);
            check_field("retire_valid while halted", 32'(retire_valid), 32'd0);
            @(posedge clk);
            #1;
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
common/rv_pkg.sv
hw/pc_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/rv_core.sv
tb/tb_rv_core.sv

/* Makefile */
# Verilator build and run for the single-cycle rv32i core

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= === PASS ===

SOURCES := $(wildcard common/*.sv hw/*.sv tb/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, not the exit code of the simulator
run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
